//--- sim.f
src/la_pkg.sv
src/la_regs.sv
src/la_dec.sv
src/la_trg.sv
src/la_acq.sv
src/la_top.sv
tests/la_tb.sv

//--- Bender.yml
package:
  name: la

sources:
  - src/la_pkg.sv
  - src/la_regs.sv
  - src/la_dec.sv
  - src/la_trg.sv
  - src/la_acq.sv
  - src/la_top.sv
  - target: test
    files:
      - tests/la_tb.sv

//--- tests/la_tb.sv
////////////////////////////////////////////////////////////
// table driven testbench for the logic analyzer top
// inputs change and outputs are read on the falling edge
// a behavioral model predicts the output stream
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module la_tb;

  import la_pkg::*;

  localparam int unsigned dcw = 17;

  // control write bits
  localparam logic [31:0] ctl_str = 32'h1;
  localparam logic [31:0] ctl_stp = 32'h2;
  localparam logic [31:0] ctl_swt = 32'h4;
  localparam logic [31:0] ctl_rst = 32'h8;

  typedef enum logic [1:0] {
    op_wr,
    op_rd,
    op_smp,
    op_idle
  } op_e;

  // one step of the test table
  typedef struct packed {
    op_e         op;
    logic [2:0]  tst;
    logic [6:0]  adr;
    logic [16:0] rep;
    logic [31:0] dat;
    logic [31:0] exp;
  } row_t;

  logic        bus;
  logic        reset;
  logic        wen;
  logic        ren;
  logic [6:0]  addr;
  logic [31:0] wdata;
  logic [31:0] rdata;
  logic        ack;
  logic [7:0]  sti_dat;
  logic        sti_vld;
  logic [7:0]  sto_dat;
  logic        sto_vld;
  logic        sto_lst;
  logic        irq;

  row_t   tbl [0:511];
  int     n_rows = 0;
  int     steps = 0;
  int     limit = 1000000;
  int     cyc = 0;
  logic [2:0] sect = 0;
  string  names [0:7];
  string  cur_tst = "reset";
  integer seed = 32'h41a1_a281;

  // expected output stream
  logic [7:0] q_dat [$];
  logic       q_lst [$];
  int         q_cyc [$];

  ////////////////////////////////////////////////////////////
  // reference model state
  ////////////////////////////////////////////////////////////

  la_state_e   m_state = la_idle;
  logic [7:0]  m_msk = 0;
  logic [7:0]  m_pol = 0;
  logic [7:0]  m_cmp_msk = 0;
  logic [7:0]  m_cmp_val = 0;
  logic [7:0]  m_edg_pos = 0;
  logic [7:0]  m_edg_neg = 0;
  logic [15:0] m_pre = 0;
  logic [15:0] m_pst = 0;
  logic [16:0] m_dec = 0;
  logic [16:0] m_dcnt = 0;
  logic [7:0]  m_prv = 0;
  logic [15:0] m_pre_cnt = 0;
  logic [15:0] m_pst_cnt = 0;

  la_top #(
    .dcw (dcw)
  ) UUT (
    .bus     (bus),
    .reset   (reset),
    .wen     (wen),
    .ren     (ren),
    .addr    (addr),
    .wdata   (wdata),
    .rdata   (rdata),
    .ack     (ack),
    .sti_dat (sti_dat),
    .sti_vld (sti_vld),
    .sto_dat (sto_dat),
    .sto_vld (sto_vld),
    .sto_lst (sto_lst),
    .irq     (irq)
  );

  initial bus = 1'b0;
  always #20 bus = ~bus;

  // cycle count and run time limit
  always @(posedge bus) begin
    cyc <= cyc + 1;
    if (cyc >= limit) begin
      $display("timeout: the run did not finish within %0d cycles", limit);
      $display("Test failed");
      $fatal(1, "simulation stopped by timeout");
    end
  end

  task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("** Error [%s] %s: expected %h, actual %h", cur_tst, what, exp, act);
      $display("Test failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // table building
  ////////////////////////////////////////////////////////////

  task automatic put(input op_e op, input logic [16:0] rep, input logic [6:0] adr,
                     input logic [31:0] dat, input logic [31:0] exp);
    row_t r;
    r.op  = op;
    r.tst = sect;
    r.adr = adr;
    r.rep = rep;
    r.dat = dat;
    r.exp = exp;
    tbl[n_rows] = r;
    n_rows = n_rows + 1;
    steps = steps + int'(rep);
  endtask

  task automatic put_wr(input logic [6:0] adr, input logic [31:0] dat);
    put(op_wr, 1, adr, dat, 0);
  endtask

  task automatic put_rd(input logic [6:0] adr, input logic [31:0] exp);
    put(op_rd, 1, adr, 0, exp);
  endtask

  // write then read back the same value
  task automatic put_wr_rd(input logic [6:0] adr, input logic [31:0] dat);
    put_wr(adr, dat);
    put_rd(adr, dat);
  endtask

  // random samples with bit 7 clear so the 0x80 compare never hits
  task automatic put_rnd(input int n);
    logic [31:0] v;
    for (int i = 0; i < n; i++) begin
      v = $random(seed);
      put(op_smp, 1, 0, v & 32'h7f, 0);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  task automatic model_write(input logic [6:0] adr, input logic [31:0] dat);
    case (adr)
      la_adr_pre:     m_pre = dat[15:0];
      la_adr_pst:     m_pst = dat[15:0];
      la_adr_cmp_msk: m_cmp_msk = dat[7:0];
      la_adr_cmp_val: m_cmp_val = dat[7:0];
      la_adr_edg_pos: m_edg_pos = dat[7:0];
      la_adr_edg_neg: m_edg_neg = dat[7:0];
      la_adr_msk:     m_msk = dat[7:0];
      la_adr_pol:     m_pol = dat[7:0];
      la_adr_dec:     m_dec = dat[16:0];
      la_adr_ctl: begin
        if (dat[3]) begin
          m_state = la_idle;
          m_pre_cnt = 0;
          m_pst_cnt = 0;
          m_dcnt = 0;
          m_prv = 0;
        end else if (dat[1]) begin
          m_state = la_idle;
        end else begin
          // software trigger only counts while armed
          if (dat[2] && m_state == la_arm) m_state = la_pst;
          if (dat[0] && m_state == la_idle) begin
            m_state = (m_pre == 0) ? la_arm : la_pre;
            m_pre_cnt = 0;
            m_pst_cnt = 0;
          end
        end
      end
      default: ;
    endcase
  endtask

  task automatic model_sample(input logic [7:0] v);
    logic trig;
    logic keep;
    logic lst;
    trig = ((v & m_cmp_msk) == (m_cmp_val & m_cmp_msk))
         && (((m_edg_pos | m_edg_neg) == 0) || ((v & ~m_prv & m_edg_pos) != 0)
             || ((~v & m_prv & m_edg_neg) != 0));
    m_prv = v;
    keep = (m_dcnt == 0);
    m_dcnt = keep ? m_dec : m_dcnt - 1;
    // a trigger on a dropped sample stays pending in pst
    if (m_state == la_arm && trig) m_state = la_pst;
    if (keep && m_state != la_idle) begin
      lst = 1'b0;
      if (m_state == la_pst) begin
        m_pst_cnt = m_pst_cnt + 1;
        if (m_pst_cnt >= m_pst) begin
          lst = 1'b1;
          m_state = la_idle;
        end
      end else begin
        if (m_pre_cnt != 16'hffff) m_pre_cnt = m_pre_cnt + 1;
        if (m_state == la_pre && m_pre_cnt == m_pre) m_state = la_arm;
      end
      q_dat.push_back((v & m_msk) ^ m_pol);
      q_lst.push_back(lst);
      q_cyc.push_back(cyc + 2);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // bus and sample drivers start and end on a falling edge
  ////////////////////////////////////////////////////////////

  task automatic do_write(input logic [6:0] adr, input logic [31:0] dat);
    wen = 1'b1;
    addr = adr;
    wdata = dat;
    model_write(adr, dat);
    @(negedge bus);
    check("ack after write", 1, ack);
    wen = 1'b0;
    @(negedge bus);
    check("ack one cycle only", 0, ack);
  endtask

  task automatic do_read(input logic [6:0] adr, input logic [31:0] exp);
    ren = 1'b1;
    addr = adr;
    @(negedge bus);
    check("ack after read", 1, ack);
    check($sformatf("read of 0x%02h", adr), exp, rdata);
    ren = 1'b0;
    @(negedge bus);
    check("ack one cycle only", 0, ack);
  endtask

  task automatic drive_sample(input logic [7:0] v);
    sti_dat = v;
    sti_vld = 1'b1;
    model_sample(v);
    @(negedge bus);
    sti_vld = 1'b0;
  endtask

  // output stream monitor
  always @(negedge bus) begin : output_monitor
    logic lst;
    if (!reset) begin
      if (sto_vld) begin
        if (q_dat.size() == 0) begin
          $display("output stream gave a sample that no input should produce");
          $display("Test failed");
          $fatal(1, "unexpected output sample");
        end else begin
          lst = q_lst.pop_front();
          check("sto_dat", q_dat.pop_front(), sto_dat);
          check("sto_lst", lst, sto_lst);
          check("irq with sto_lst", lst, irq);
          check("output cycle", q_cyc.pop_front(), cyc);
        end
      end else begin
        check("sto_lst without sto_vld", 0, sto_lst);
        check("irq without sto_vld", 0, irq);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // test table and main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    row_t r;
    names[0] = "reset";
    names[1] = "readback";
    names[2] = "conditioning";
    names[3] = "decimation";
    names[4] = "level trigger";
    names[5] = "edge trigger";
    names[6] = "stop and saturation";
    names[7] = "drain";
    reset = 1'b1;
    wen = 1'b0;
    ren = 1'b0;
    addr = '0;
    wdata = '0;
    sti_dat = '0;
    sti_vld = 1'b0;

    // register readback and idle status after reset
    sect = 1;
    put_rd(la_adr_sts, 32'(la_idle));
    put_wr_rd(la_adr_pre, 32'h1234);
    put_wr_rd(la_adr_pst, 32'hbeef);
    put_wr_rd(la_adr_cmp_msk, 32'h5a);
    put_wr_rd(la_adr_cmp_val, 32'hc3);
    put_wr_rd(la_adr_edg_pos, 32'h81);
    put_wr_rd(la_adr_edg_neg, 32'h18);
    put_wr_rd(la_adr_msk, 32'hf0);
    put_wr_rd(la_adr_pol, 32'h0f);
    put_wr_rd(la_adr_dec, 32'h1_5a5a);
    put_rd(7'h30, 32'h0);

    // conditioning without decimation and a software trigger
    sect = 2;
    put_wr(la_adr_msk, 32'hf3);
    put_wr(la_adr_pol, 32'h5a);
    put_wr(la_adr_dec, 32'h0);
    put_wr(la_adr_pre, 32'd4);
    put_wr(la_adr_pst, 32'd3);
    put_wr(la_adr_cmp_msk, 32'h80);
    put_wr(la_adr_cmp_val, 32'h80);
    put_wr(la_adr_edg_pos, 32'h0);
    put_wr(la_adr_edg_neg, 32'h0);
    put_wr(la_adr_ctl, ctl_rst);
    put_wr(la_adr_ctl, ctl_str);
    put_rnd(6);
    put_wr(la_adr_ctl, ctl_swt);
    put_rnd(3);
    put(op_idle, 2, 0, 0, 0);
    put_rd(la_adr_sts, 32'(la_idle));
    put_rd(la_adr_sts_pre, 32'd6);
    put_rd(la_adr_sts_pst, 32'd3);

    // keep every third sample
    sect = 3;
    put_wr(la_adr_dec, 32'd2);
    put_wr(la_adr_pre, 32'd3);
    put_wr(la_adr_pst, 32'd2);
    put_wr(la_adr_ctl, ctl_rst);
    put_wr(la_adr_ctl, ctl_str);
    put_rnd(14);
    put(op_idle, 2, 0, 0, 0);
    put_rd(la_adr_sts, 32'(la_arm));
    put_rd(la_adr_sts_pre, 32'd5);
    put_wr(la_adr_ctl, ctl_swt);
    put_rnd(5);
    put(op_idle, 2, 0, 0, 0);
    put_rd(la_adr_sts, 32'(la_idle));
    put_rd(la_adr_sts_pre, 32'd5);
    put_rd(la_adr_sts_pst, 32'd2);

    // compare trigger whose first hit falls into pre
    sect = 4;
    put_wr(la_adr_dec, 32'h0);
    put_wr(la_adr_pre, 32'd2);
    put_wr(la_adr_pst, 32'd4);
    put_wr(la_adr_msk, 32'hff);
    put_wr(la_adr_pol, 32'h0);
    put_wr(la_adr_cmp_msk, 32'hff);
    put_wr(la_adr_cmp_val, 32'h3c);
    put_wr(la_adr_ctl, ctl_rst);
    put_wr(la_adr_ctl, ctl_str);
    put(op_smp, 1, 0, 32'h3c, 0);
    put(op_smp, 1, 0, 32'h11, 0);
    put(op_smp, 1, 0, 32'h22, 0);
    put(op_smp, 1, 0, 32'h3c, 0);
    put(op_smp, 1, 0, 32'h01, 0);
    put(op_smp, 1, 0, 32'h3c, 0);
    put(op_smp, 1, 0, 32'h02, 0);
    put(op_smp, 1, 0, 32'h44, 0);
    put(op_idle, 2, 0, 0, 0);
    put_rd(la_adr_sts, 32'(la_idle));
    put_rd(la_adr_sts_pre, 32'd3);
    put_rd(la_adr_sts_pst, 32'd4);

    // rising edge on bit 3 while a steady high must not fire
    sect = 5;
    put_wr(la_adr_cmp_msk, 32'h0);
    put_wr(la_adr_edg_pos, 32'h08);
    put_wr(la_adr_pre, 32'd0);
    put_wr(la_adr_pst, 32'd2);
    put_wr(la_adr_ctl, ctl_rst);
    put(op_smp, 1, 0, 32'h08, 0);
    put(op_smp, 1, 0, 32'h0c, 0);
    put_wr(la_adr_ctl, ctl_str);
    put(op_smp, 1, 0, 32'h08, 0);
    put(op_smp, 1, 0, 32'h0f, 0);
    put(op_smp, 1, 0, 32'h07, 0);
    put(op_smp, 1, 0, 32'h18, 0);
    put(op_smp, 1, 0, 32'h00, 0);
    put(op_idle, 2, 0, 0, 0);
    put_rd(la_adr_sts, 32'(la_idle));
    put_rd(la_adr_sts_pre, 32'd3);
    put_rd(la_adr_sts_pst, 32'd2);

    // full pre window saturates the count before a stop
    sect = 6;
    put_wr(la_adr_edg_pos, 32'h0);
    put_wr(la_adr_cmp_msk, 32'h80);
    put_wr(la_adr_cmp_val, 32'h80);
    put_wr(la_adr_pre, 32'hffff);
    put_wr(la_adr_pst, 32'd4);
    put_wr(la_adr_ctl, ctl_rst);
    put_wr(la_adr_ctl, ctl_str);
    put(op_smp, 17'd65540, 0, 32'h00, 0);
    put(op_idle, 2, 0, 0, 0);
    put_rd(la_adr_sts, 32'(la_arm));
    put_rd(la_adr_sts_pre, 32'h8000_ffff);
    put(op_smp, 3, 0, 32'h01, 0);
    put_wr(la_adr_ctl, ctl_stp);
    put(op_smp, 3, 0, 32'h02, 0);
    put(op_idle, 2, 0, 0, 0);
    put_rd(la_adr_sts, 32'(la_idle));
    put_rd(la_adr_sts_pre, 32'h8000_ffff);
    put_wr(la_adr_ctl, ctl_rst);
    put_rd(la_adr_sts_pre, 32'h0);
    sect = 7;
    put(op_idle, 4, 0, 0, 0);

    limit = steps * 4 + 100;

    repeat (8) @(negedge bus);
    reset = 1'b0;
    check("ack after reset", 0, ack);
    check("sto_vld after reset", 0, sto_vld);
    check("irq after reset", 0, irq);

    for (int i = 0; i < n_rows; i++) begin
      r = tbl[i];
      cur_tst = names[r.tst];
      case (r.op)
        op_wr: do_write(r.adr, r.dat);
        op_rd: do_read(r.adr, r.exp);
        op_smp: begin
          for (int k = 0; k < int'(r.rep); k++) begin
            drive_sample(r.dat[7:0]);
          end
        end
        default: repeat (int'(r.rep)) @(negedge bus);
      endcase
    end

    check("samples never emitted", 0, q_dat.size());
    $display("Test completed successfully");
    $finish;
  end

endmodule : la_tb

`default_nettype wire

//--- src/la_top.sv
////////////////////////////////////////////////////////////
// logic analyzer top, single clock, sync active high reset
// kept sample reaches sto_vld two cycles after input
// dcw sets the decimation factor width
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module la_top #(
  parameter int unsigned dcw = 17
) (
  input  wire logic                       bus,
  input  wire logic                       reset,
  // register bus
  input  wire logic                       wen,
  input  wire logic                       ren,
  input  wire logic [la_pkg::la_baw-1:0]  addr,
  input  wire logic [31:0]                wdata,
  output      logic [31:0]                rdata,
  output      logic                       ack,
  // sample input
  input  wire logic [la_pkg::la_dw-1:0]   sti_dat,
  input  wire logic                       sti_vld,
  // sample output
  output      logic [la_pkg::la_dw-1:0]   sto_dat,
  output      logic                       sto_vld,
  output      logic                       sto_lst,
  output      logic                       irq
);

  import la_pkg::*;

  la_cfg_t          cfg;
  logic [dcw-1:0]   cfg_dec;
  la_ctl_t          ctl;
  la_sts_t          sts;
  // decimator to acquisition
  logic [la_dw-1:0] dec_dat;
  logic             dec_vld;
  logic             trg;

  la_regs #(
    .dcw (dcw)
  ) u_regs (
    .bus     (bus),
    .reset   (reset),
    .wen     (wen),
    .ren     (ren),
    .addr    (addr),
    .wdata   (wdata),
    .rdata   (rdata),
    .ack     (ack),
    .cfg     (cfg),
    .cfg_dec (cfg_dec),
    .ctl     (ctl),
    .sts     (sts)
  );

  ////////////////////////////////////////////////////////////
  // parallel data path, both see the same raw sample
  ////////////////////////////////////////////////////////////

  la_dec #(
    .dcw (dcw)
  ) u_dec (
    .bus     (bus),
    .reset   (reset),
    .acq_rst (ctl.rst),
    .cfg     (cfg),
    .cfg_dec (cfg_dec),
    .sti_dat (sti_dat),
    .sti_vld (sti_vld),
    .dec_dat (dec_dat),
    .dec_vld (dec_vld)
  );

  la_trg u_trg (
    .bus     (bus),
    .reset   (reset),
    .acq_rst (ctl.rst),
    .cfg     (cfg),
    .sti_dat (sti_dat),
    .sti_vld (sti_vld),
    .trg     (trg)
  );

  la_acq u_acq (
    .bus     (bus),
    .reset   (reset),
    .ctl     (ctl),
    .cfg     (cfg),
    .dec_dat (dec_dat),
    .dec_vld (dec_vld),
    .trg     (trg),
    .sts     (sts),
    .sto_dat (sto_dat),
    .sto_vld (sto_vld),
    .sto_lst (sto_lst),
    .irq     (irq)
  );

endmodule : la_top

`default_nettype wire

//--- src/la_acq.sv
////////////////////////////////////////////////////////////
// pre/post trigger acquisition and output strobe stream
// no back-pressure, one output per kept sample outside idle
// a trigger on a dropped sample counts the next kept one
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module la_acq (
  input  wire logic                       bus,
  input  wire logic                       reset,
  input  wire la_pkg::la_ctl_t            ctl,
  input  wire la_pkg::la_cfg_t            cfg,
  // decimated samples and trigger
  input  wire logic [la_pkg::la_dw-1:0]   dec_dat,
  input  wire logic                       dec_vld,
  input  wire logic                       trg,
  output      la_pkg::la_sts_t            sts,
  // output stream
  output      logic [la_pkg::la_dw-1:0]   sto_dat,
  output      logic                       sto_vld,
  output      logic                       sto_lst,
  output      logic                       irq
);

  import la_pkg::*;

  localparam logic [la_cw-1:0] cnt_max = '1;

  la_state_e        state;
  logic [la_cw-1:0] pre_cnt;
  logic             pre_ovf;
  logic [la_cw-1:0] pst_cnt;
  // stop or acquisition reset
  logic             brk;
  logic             trg_any;
  // kept sample falls into the pre or post window
  logic             pre_smp;
  logic             pst_smp;
  // final post trigger sample
  logic             pst_end;

  assign brk     = ctl.stp | ctl.rst;
  assign trg_any = trg | ctl.swt;

  // trigger sample itself is the first post sample
  assign pre_smp = dec_vld & ~brk
                 & ((state == la_pre) | ((state == la_arm) & ~trg_any));
  assign pst_smp = dec_vld & ~brk
                 & ((state == la_pst) | ((state == la_arm) & trg_any));
  assign pst_end = pst_smp & (({1'b0, pst_cnt} + 1'b1) >= {1'b0, cfg.pst});

  ////////////////////////////////////////////////////////////
  // state machine
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (reset || brk) begin
      state <= la_idle;
    end else begin
      case (state)
        la_idle: if (ctl.str) state <= (cfg.pre == '0) ? la_arm : la_pre;
        // triggers here are ignored
        la_pre:  if (dec_vld && (pre_cnt + 1'b1 == cfg.pre)) state <= la_arm;
        la_arm: begin
          if (pst_end) begin
            state <= la_idle;
          end else if (trg_any) begin
            state <= la_pst;
          end
        end
        la_pst:  if (pst_end) state <= la_idle;
        default: state <= la_idle;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // window counters
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (reset || ctl.rst || (ctl.str && (state == la_idle))) begin
      pre_cnt <= '0;
      pre_ovf <= 1'b0;
      pst_cnt <= '0;
    end else begin
      // saturating pre count, flag set on reaching the top
      if (pre_smp && (pre_cnt != cnt_max)) begin
        pre_cnt <= pre_cnt + 1'b1;
        if (pre_cnt == cnt_max - 1'b1) begin
          pre_ovf <= 1'b1;
        end
      end
      if (pst_smp) begin
        pst_cnt <= pst_cnt + 1'b1;
      end
    end
  end

  assign sts = '{state: state, pre_cnt: pre_cnt, pre_ovf: pre_ovf,
                 pst_cnt: pst_cnt, spare: 1'b0};

  ////////////////////////////////////////////////////////////
  // output stream
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (reset) begin
      sto_vld <= 1'b0;
      sto_lst <= 1'b0;
      irq     <= 1'b0;
    end else begin
      sto_vld <= dec_vld & (state != la_idle) & ~brk;
      sto_lst <= pst_end;
      irq     <= pst_end;
    end
  end

  always_ff @(posedge bus) begin
    if (dec_vld) begin
      sto_dat <= dec_dat;
    end
  end

endmodule : la_acq

`default_nettype wire

//--- src/la_trg.sv
////////////////////////////////////////////////////////////
// compare and edge trigger on the raw input
// trg is registered, one cycle after the sample
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module la_trg (
  input  wire logic                       bus,
  input  wire logic                       reset,
  input  wire logic                       acq_rst,
  input  wire la_pkg::la_cfg_t            cfg,
  input  wire logic [la_pkg::la_dw-1:0]   sti_dat,
  input  wire logic                       sti_vld,
  output      logic                       trg
);

  import la_pkg::*;

  // previous valid sample
  logic [la_dw-1:0] prv;
  // bitwise edges against the previous sample
  logic [la_dw-1:0] rise;
  logic [la_dw-1:0] fall;
  logic             cmp_ok;
  logic             edg_ok;

  ////////////////////////////////////////////////////////////
  // condition
  ////////////////////////////////////////////////////////////

  // masked bits must match the compare value
  assign cmp_ok = ((sti_dat ^ cfg.cmp_val) & cfg.cmp_msk) == '0;

  assign rise = sti_dat & ~prv;
  assign fall = ~sti_dat & prv;

  // no edge masks means level only
  assign edg_ok = ((cfg.edg_pos == '0) && (cfg.edg_neg == '0))
                | (|(rise & cfg.edg_pos))
                | (|(fall & cfg.edg_neg));

  ////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (reset || acq_rst) begin
      prv <= '0;
      trg <= 1'b0;
    end else begin
      trg <= sti_vld & cmp_ok & edg_ok;
      if (sti_vld) begin
        prv <= sti_dat;
      end
    end
  end

endmodule : la_trg

`default_nettype wire

//--- src/la_dec.sv
////////////////////////////////////////////////////////////
// input conditioning and decimation, one cycle latency
// keeps first accepted sample, then every (cfg_dec+1)-th
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module la_dec #(
  parameter int unsigned dcw = 17
) (
  input  wire logic                       bus,
  input  wire logic                       reset,
  input  wire logic                       acq_rst,
  input  wire la_pkg::la_cfg_t            cfg,
  input  wire logic [dcw-1:0]             cfg_dec,
  // raw samples
  input  wire logic [la_pkg::la_dw-1:0]   sti_dat,
  input  wire logic                       sti_vld,
  // conditioned, decimated samples
  output      logic [la_pkg::la_dw-1:0]   dec_dat,
  output      logic                       dec_vld
);

  // samples left to drop before the next kept one
  logic [dcw-1:0] cnt;
  logic           keep;

  assign keep = (cnt == '0);

  always_ff @(posedge bus) begin
    if (reset || acq_rst) begin
      cnt     <= '0;
      dec_vld <= 1'b0;
    end else begin
      dec_vld <= sti_vld & keep;
      if (sti_vld) begin
        // reload on keep, count down otherwise
        cnt <= keep ? cfg_dec : cnt - 1'b1;
      end
    end
  end

  // mask then polarity
  always_ff @(posedge bus) begin
    if (sti_vld) begin
      dec_dat <= (sti_dat & cfg.msk) ^ cfg.pol;
    end
  end

endmodule : la_dec

`default_nettype wire

//--- src/la_regs.sv
////////////////////////////////////////////////////////////
// register bank on the simple strobe bus
// ack follows wen/ren by one cycle, read data valid with ack
// control writes give one-cycle pulses, dcw must be <= 32
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module la_regs #(
  parameter int unsigned dcw = 17
) (
  input  wire logic                       bus,
  input  wire logic                       reset,
  // bus access
  input  wire logic                       wen,
  input  wire logic                       ren,
  input  wire logic [la_pkg::la_baw-1:0]  addr,
  input  wire logic [31:0]                wdata,
  output      logic [31:0]                rdata,
  output      logic                       ack,
  // data path side
  output      la_pkg::la_cfg_t            cfg,
  output      logic [dcw-1:0]             cfg_dec,
  output      la_pkg::la_ctl_t            ctl,
  input  wire la_pkg::la_sts_t            sts
);

  import la_pkg::*;

  // one cycle handshake
  always_ff @(posedge bus) begin
    if (reset) begin
      ack <= 1'b0;
    end else begin
      ack <= wen | ren;
    end
  end

  ////////////////////////////////////////////////////////////
  // write side
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (reset) begin
      cfg     <= '0;
      cfg_dec <= '0;
    end else if (wen) begin
      case (addr)
        la_adr_pre:     cfg.pre     <= wdata[la_cw-1:0];
        la_adr_pst:     cfg.pst     <= wdata[la_cw-1:0];
        la_adr_cmp_msk: cfg.cmp_msk <= wdata[la_dw-1:0];
        la_adr_cmp_val: cfg.cmp_val <= wdata[la_dw-1:0];
        la_adr_edg_pos: cfg.edg_pos <= wdata[la_dw-1:0];
        la_adr_edg_neg: cfg.edg_neg <= wdata[la_dw-1:0];
        la_adr_msk:     cfg.msk     <= wdata[la_dw-1:0];
        la_adr_pol:     cfg.pol     <= wdata[la_dw-1:0];
        la_adr_dec:     cfg_dec     <= wdata[dcw-1:0];
        default: ;
      endcase
    end
  end

  // control pulses, low again one cycle later
  always_ff @(posedge bus) begin
    if (reset) begin
      ctl <= '0;
    end else if (wen && (addr == la_adr_ctl)) begin
      ctl <= la_ctl_t'(wdata[3:0]);
    end else begin
      ctl <= '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // read side
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (ren) begin
      case (addr)
        // control bits are pulses, nothing to return
        la_adr_ctl:     rdata <= '0;
        la_adr_sts:     rdata <= 32'(sts.state);
        la_adr_pre:     rdata <= 32'(cfg.pre);
        la_adr_pst:     rdata <= 32'(cfg.pst);
        // overflow flag on top of the count
        la_adr_sts_pre: rdata <= {sts.pre_ovf, 31'(sts.pre_cnt)};
        la_adr_sts_pst: rdata <= {sts.spare, 31'(sts.pst_cnt)};
        la_adr_cmp_msk: rdata <= 32'(cfg.cmp_msk);
        la_adr_cmp_val: rdata <= 32'(cfg.cmp_val);
        la_adr_edg_pos: rdata <= 32'(cfg.edg_pos);
        la_adr_edg_neg: rdata <= 32'(cfg.edg_neg);
        la_adr_msk:     rdata <= 32'(cfg.msk);
        la_adr_pol:     rdata <= 32'(cfg.pol);
        la_adr_dec:     rdata <= 32'(cfg_dec);
        default:        rdata <= '0;
      endcase
    end
  end

endmodule : la_regs

`default_nettype wire

//--- src/la_pkg.sv
////////////////////////////////////////////////////////////
// shared widths, register map and types of the analyzer
// sample and pre/post counter widths are fixed here
// decimation factor width is a module parameter instead
////////////////////////////////////////////////////////////

`default_nettype none

package la_pkg;

  // sample width
  localparam int unsigned la_dw = 8;
  // pre/post trigger counter width
  localparam int unsigned la_cw = 16;
  // significant bus address bits
  localparam int unsigned la_baw = 7;

  ////////////////////////////////////////////////////////////
  // register map
  ////////////////////////////////////////////////////////////

  localparam logic [la_baw-1:0] la_adr_ctl     = 'h00;
  localparam logic [la_baw-1:0] la_adr_sts     = 'h0c;
  localparam logic [la_baw-1:0] la_adr_pre     = 'h10;
  localparam logic [la_baw-1:0] la_adr_pst     = 'h14;
  localparam logic [la_baw-1:0] la_adr_sts_pre = 'h18;
  localparam logic [la_baw-1:0] la_adr_sts_pst = 'h1c;
  localparam logic [la_baw-1:0] la_adr_cmp_msk = 'h20;
  localparam logic [la_baw-1:0] la_adr_cmp_val = 'h24;
  localparam logic [la_baw-1:0] la_adr_edg_pos = 'h28;
  localparam logic [la_baw-1:0] la_adr_edg_neg = 'h2c;
  localparam logic [la_baw-1:0] la_adr_msk     = 'h40;
  localparam logic [la_baw-1:0] la_adr_pol     = 'h44;
  localparam logic [la_baw-1:0] la_adr_dec     = 'h48;

  ////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////

  // acquisition state
  typedef enum logic [1:0] {
    la_idle,
    la_pre,
    la_arm,
    la_pst
  } la_state_e;

  // control pulses, str sits in bit 0 of the control write
  typedef struct packed {
    logic rst;
    logic swt;
    logic stp;
    logic str;
  } la_ctl_t;

  // data path configuration
  typedef struct packed {
    logic [la_dw-1:0] msk;
    logic [la_dw-1:0] pol;
    logic [la_dw-1:0] cmp_msk;
    logic [la_dw-1:0] cmp_val;
    logic [la_dw-1:0] edg_pos;
    logic [la_dw-1:0] edg_neg;
    logic [la_cw-1:0] pre;
    logic [la_cw-1:0] pst;
  } la_cfg_t;

  // acquisition status
  typedef struct packed {
    la_state_e        state;
    logic [la_cw-1:0] pre_cnt;
    logic             pre_ovf;
    logic [la_cw-1:0] pst_cnt;
    logic             spare;
  } la_sts_t;

endpackage : la_pkg

`default_nettype wire
